//--- piano_control_testdata.txt
// Inputs, MSB first: reset start enter modes[1:0] error_choice[1:0] delay_done rounds_done
//   note_made note_correct time_correct beat_low address_at_round timeout song_end
// Expected: 26 strobes clear_note_count..clear_options, 3'b0, menu_sel, 2'b0, debug_state
4800 000000C000  // menu idle, start
0800 000020001C  // menu start
2800 000018001D  // mode page
2800 000014011E  // bpm page
2800 000012021F  // tone page
2800 0000110320  // song page
0800 000000002F  // launch
0800 2A80000001  // init
0800 9000000002  // round start holds
0900 9000000002
0800 2200000003  // show
0808 010C000004  // show wait
0800 4000000005  // show next
0800 2200000003
080C 010C000004
0800 A080000006  // note start
0840 0240800007  // note wait
0800 0134000017  // note sound
0810 0000400009  // compare, wrong note
0800 0281000014
0800 0000200021  // error menu start
0C00 0000100422  // error menu holds
2C00 0000100422  // retry note
0800 A080000006
0840 0240800007
0800 0134000017
08B4 0000400009  // last note of last round
4800 000200000A  // won, start again
0800 2A80000001
0900 9000000002
0800 2200000003
080C 010C000004
0800 A080000006
0802 0240800007  // timeout
0800 0281000015  // wrong time
0800 0000200021
2A00 0000100422  // retry round
0900 9000000002
0800 2200000003
080C 010C000004
0800 A080000006
0840 0240800007
0800 0134000017
0834 0000400009
0800 4000000013  // advance
0800 000000001B  // record
0801 028000001A  // check end, song over
0800 000200000A
9000 000000C000  // reset, free play
5000 000000C000
1000 000020001C
3000 000018001D
3000 000014011E
3000 000012021F  // tone page skips song page
1000 000000002F
1000 2A80000001
1040 0100000023  // free wait
1040 0134000017
1000 0134000017
1000 0100000023

//--- project.f
control_pkg.sv
menu_sequencer.sv
play_sequencer.sv
control_decoder.sv
piano_control.sv
clock_gen.sv
piano_control_tb.sv

//--- Bender.yml
package:
  name: piano_control

sources:
  - control_pkg.sv
  - menu_sequencer.sv
  - play_sequencer.sv
  - control_decoder.sv
  - piano_control.sv
  - target: test
    files:
      - clock_gen.sv
      - piano_control_tb.sv

//--- piano_control_tb.sv
`timescale 1ns/100ps

module piano_control_tb;
    import control_pkg::*;

    localparam int MAX_VECTORS = 64;

    logic                          clock;
    logic                          gen_reset;
    logic                          vector_reset;
    logic                          reset;
    logic                          start, enter, delay_done, rounds_done, note_made;
    logic                          note_correct, time_correct, beat_low, address_at_round;
    logic                          timeout, song_end;
    logic [MODE_WIDTH-1:0]         modes;
    logic [ERROR_CHOICE_WIDTH-1:0] error_choice;
    logic                          clear_note_count, count_note, clear_delay, count_delay;
    logic                          clear_round, count_round, clear_beat, count_beat;
    logic                          clear_timeout, count_timeout, store_note, tone_on;
    logic                          leds_from_memory, leds_on, won, lost;
    logic                          player_turn, store_error, start_menu, show_menu;
    logic                          store_mode, store_bpm, store_tone, store_song;
    logic                          clear_note, clear_options;
    logic [MENU_SEL_WIDTH-1:0]     menu_sel;
    logic [DEBUG_WIDTH-1:0]        debug_state;

    // Inputs in even words and expected outputs in odd words
    logic [39:0] vectors [0:2*MAX_VECTORS-1];
    logic [25:0] actual;
    int          vector_count;
    int          wait_cycles;
    bit          replay_done;

    string strobe_names [26] = '{
        "clear_note_count", "count_note", "clear_delay", "count_delay", "clear_round",
        "count_round", "clear_beat", "count_beat", "clear_timeout", "count_timeout",
        "store_note", "tone_on", "leds_from_memory", "leds_on", "won", "lost",
        "player_turn", "store_error", "start_menu", "show_menu", "store_mode",
        "store_bpm", "store_tone", "store_song", "clear_note", "clear_options"
    };

    assign reset = gen_reset | vector_reset;

    // Same bit order as the expected word in the data file
    assign actual = {clear_note_count, count_note, clear_delay, count_delay, clear_round,
                     count_round, clear_beat, count_beat, clear_timeout, count_timeout,
                     store_note, tone_on, leds_from_memory, leds_on, won, lost,
                     player_turn, store_error, start_menu, show_menu, store_mode,
                     store_bpm, store_tone, store_song, clear_note, clear_options};

    clock_gen clock_gen_i (
        .clock(clock),
        .reset(gen_reset)
    );

    piano_control piano_control_i (.*);

    task automatic stop_on_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [7:0] actual_value,
                                 input logic [7:0] expected_value);
        if (actual_value !== expected_value) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual_value,
                     expected_value);
            stop_on_failure();
        end
    endtask

    task automatic check_outputs(input logic [39:0] expected);
        for (int k = 0; k < 26; k++) begin
            compare_value(strobe_names[k], actual[25-k], expected[39-k]);
        end
        compare_value("menu_sel", menu_sel, expected[10:8]);
        compare_value("debug_state", debug_state, expected[5:0]);
    endtask

    // Drive 1 ns after the edge and check just before the next one
    task automatic replay_vectors();
        for (int i = 0; i < vector_count; i++) begin
            @(posedge clock);
            #1;
            {vector_reset, start, enter, modes, error_choice, delay_done, rounds_done,
             note_made, note_correct, time_correct, beat_low, address_at_round, timeout,
             song_end} = vectors[2*i][15:0];
            #2.5;
            check_outputs(vectors[2*i+1]);
        end
        replay_done = 1'b1;
    endtask

    initial begin
        {vector_reset, start, enter, modes, error_choice, delay_done, rounds_done, note_made,
         note_correct, time_correct, beat_low, address_at_round, timeout, song_end} = '0;
        replay_done  = 1'b0;
        vector_count = 0;
        wait_cycles  = 0;
        // Words past the data keep a marker above the 16 input bits
        for (int i = 0; i < 2 * MAX_VECTORS; i++) begin
            vectors[i] = 40'hFF_0000_0000 + i;
        end
        $readmemh("piano_control_testdata.txt", vectors);
        while (vector_count < MAX_VECTORS && vectors[2*vector_count][39:16] == '0) begin
            vector_count++;
        end
        do begin
            @(posedge clock);
            wait_cycles++;
        end while (gen_reset !== 1'b0 && wait_cycles < 8);
        if (vector_count == 0) begin
            $display("No test vectors were found in the data file");
            stop_on_failure();
        end else if (gen_reset !== 1'b0) begin
            $display("Reset was never released");
            stop_on_failure();
        end else begin
            fork
                replay_vectors();
            join_none
            wait_cycles = 0;
            while (!replay_done && wait_cycles < 2 * vector_count) begin
                @(posedge clock);
                wait_cycles++;
            end
            if (replay_done) begin
                $display("No errors");
                $finish;
            end else begin
                $display("Timed out before all test vectors were replayed");
                stop_on_failure();
            end
        end
    end

endmodule

//--- clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clock,
    output logic reset
);
    localparam real HALF_PERIOD = 2.0;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
    end

endmodule

//--- piano_control.sv
`timescale 1ns/100ps

module piano_control (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic                                       start,
    input  logic                                       enter,
    input  logic [control_pkg::MODE_WIDTH-1:0]         modes,
    input  logic [control_pkg::ERROR_CHOICE_WIDTH-1:0] error_choice,
    input  logic                                       delay_done,
    input  logic                                       rounds_done,
    input  logic                                       note_made,
    input  logic                                       note_correct,
    input  logic                                       time_correct,
    input  logic                                       beat_low,
    input  logic                                       address_at_round,
    input  logic                                       timeout,
    input  logic                                       song_end,
    output logic                                       clear_note_count,
    output logic                                       count_note,
    output logic                                       clear_delay,
    output logic                                       count_delay,
    output logic                                       clear_round,
    output logic                                       count_round,
    output logic                                       clear_beat,
    output logic                                       count_beat,
    output logic                                       clear_timeout,
    output logic                                       count_timeout,
    output logic                                       store_note,
    output logic                                       clear_note,
    output logic                                       clear_options,
    output logic                                       leds_from_memory,
    output logic                                       leds_on,
    output logic                                       tone_on,
    output logic                                       store_mode,
    output logic                                       store_bpm,
    output logic                                       store_tone,
    output logic                                       store_song,
    output logic                                       store_error,
    output logic                                       start_menu,
    output logic                                       show_menu,
    output logic [control_pkg::MENU_SEL_WIDTH-1:0]     menu_sel,
    output logic                                       won,
    output logic                                       lost,
    output logic                                       player_turn,
    output logic [control_pkg::DEBUG_WIDTH-1:0]        debug_state
);
    import control_pkg::*;

    menu_state_t menu_state;
    play_state_t play_state;
    logic        game_start;

    // Setup pages that launch the game once
    menu_sequencer menu_sequencer_i (.*);

    play_sequencer play_sequencer_i (.*);

    // Moore strobes from both states
    control_decoder control_decoder_i (.*);

endmodule

//--- control_decoder.sv
`timescale 1ns/100ps

module control_decoder (
    input  control_pkg::menu_state_t                 menu_state,
    input  control_pkg::play_state_t                 play_state,
    output logic                                     clear_note_count,
    output logic                                     count_note,
    output logic                                     clear_delay,
    output logic                                     count_delay,
    output logic                                     clear_round,
    output logic                                     count_round,
    output logic                                     clear_beat,
    output logic                                     count_beat,
    output logic                                     clear_timeout,
    output logic                                     count_timeout,
    output logic                                     store_note,
    output logic                                     clear_note,
    output logic                                     clear_options,
    output logic                                     leds_from_memory,
    output logic                                     leds_on,
    output logic                                     tone_on,
    output logic                                     store_mode,
    output logic                                     store_bpm,
    output logic                                     store_tone,
    output logic                                     store_song,
    output logic                                     store_error,
    output logic                                     start_menu,
    output logic                                     show_menu,
    output logic [control_pkg::MENU_SEL_WIDTH-1:0]   menu_sel,
    output logic                                     won,
    output logic                                     lost,
    output logic                                     player_turn,
    output logic [control_pkg::DEBUG_WIDTH-1:0]      debug_state
);
    import control_pkg::*;

    function automatic logic [DEBUG_WIDTH-1:0] play_code(input play_state_t state);
        case (state)
            PLAY_INIT:             return DBG_PLAY_INIT;
            PLAY_ROUND_START:      return DBG_PLAY_ROUND_START;
            PLAY_SHOW:             return DBG_PLAY_SHOW;
            PLAY_SHOW_WAIT:        return DBG_PLAY_SHOW_WAIT;
            PLAY_SHOW_NEXT:        return DBG_PLAY_SHOW_NEXT;
            PLAY_NOTE_START:       return DBG_PLAY_NOTE_START;
            PLAY_NOTE_WAIT:        return DBG_PLAY_NOTE_WAIT;
            PLAY_NOTE_SOUND:       return DBG_PLAY_NOTE_SOUND;
            PLAY_COMPARE:          return DBG_PLAY_COMPARE;
            PLAY_NEXT_NOTE:        return DBG_PLAY_NEXT_NOTE;
            PLAY_ADVANCE:          return DBG_PLAY_ADVANCE;
            PLAY_RECORD:           return DBG_PLAY_RECORD;
            PLAY_CHECK_END:        return DBG_PLAY_CHECK_END;
            PLAY_NEXT_ROUND:       return DBG_PLAY_NEXT_ROUND;
            PLAY_WON:              return DBG_PLAY_WON;
            PLAY_WRONG_NOTE:       return DBG_PLAY_WRONG_NOTE;
            PLAY_WRONG_TIME:       return DBG_PLAY_WRONG_TIME;
            PLAY_ERROR_MENU_START: return DBG_PLAY_ERROR_START;
            PLAY_ERROR_MENU:       return DBG_PLAY_ERROR_MENU;
            PLAY_FREE_WAIT:        return DBG_PLAY_FREE_WAIT;
            default:               return DBG_PLAY_IDLE;
        endcase
    endfunction

    // --------------------------------------------------
    // Game strobes from the play state only
    // --------------------------------------------------
    always_comb begin
        clear_note_count = (play_state inside {PLAY_ROUND_START, PLAY_NOTE_START});
        count_note       = (play_state inside {PLAY_ADVANCE, PLAY_SHOW_NEXT, PLAY_NEXT_NOTE});
        clear_delay      = (play_state inside {PLAY_SHOW, PLAY_INIT, PLAY_NOTE_START});
        count_delay      = (play_state == PLAY_ROUND_START);
        clear_round      = (play_state == PLAY_INIT);
        count_round      = (play_state == PLAY_NEXT_ROUND);
        clear_beat       = (play_state inside {PLAY_SHOW, PLAY_NOTE_WAIT, PLAY_WRONG_NOTE,
                                               PLAY_WRONG_TIME, PLAY_INIT, PLAY_CHECK_END});
        count_beat       = (play_state inside {PLAY_SHOW_WAIT, PLAY_NOTE_SOUND,
                                               PLAY_FREE_WAIT});
        clear_timeout    = (play_state inside {PLAY_NEXT_NOTE, PLAY_NOTE_START, PLAY_INIT,
                                               PLAY_WRONG_NOTE, PLAY_WRONG_TIME,
                                               PLAY_CHECK_END});
        count_timeout    = (play_state == PLAY_NOTE_WAIT);
        player_turn      = (play_state == PLAY_NOTE_WAIT);
        store_note       = (play_state == PLAY_NOTE_SOUND);
        tone_on          = (play_state == PLAY_NOTE_SOUND);
        leds_from_memory = (play_state == PLAY_SHOW_WAIT);
        leds_on          = (play_state inside {PLAY_SHOW_WAIT, PLAY_NOTE_SOUND});
        store_error      = (play_state == PLAY_COMPARE);
        won              = (play_state == PLAY_WON);
        lost             = (play_state inside {PLAY_WRONG_NOTE, PLAY_WRONG_TIME});
    end

    // --------------------------------------------------
    // Menu outputs handed to the game after launch
    // --------------------------------------------------
    always_comb begin
        clear_note    = 1'b0;
        clear_options = 1'b0;
        start_menu    = 1'b0;
        show_menu     = 1'b0;
        menu_sel      = '0;
        store_mode    = 1'b0;
        store_bpm     = 1'b0;
        store_tone    = 1'b0;
        store_song    = 1'b0;
        debug_state   = DBG_MENU_IDLE;
        if (menu_state != MENU_PLAYING) begin
            case (menu_state)
                MENU_IDLE: begin
                    clear_note    = 1'b1;
                    clear_options = 1'b1;
                end
                MENU_START: begin
                    start_menu  = 1'b1;
                    debug_state = DBG_MENU_START;
                end
                MENU_WAIT_MODE: begin
                    store_mode  = 1'b1;
                    show_menu   = 1'b1;
                    debug_state = DBG_MENU_WAIT_MODE;
                end
                MENU_WAIT_BPM: begin
                    store_bpm   = 1'b1;
                    show_menu   = 1'b1;
                    menu_sel    = MENU_SEL_WIDTH'(1);
                    debug_state = DBG_MENU_WAIT_BPM;
                end
                MENU_WAIT_TONE: begin
                    store_tone  = 1'b1;
                    show_menu   = 1'b1;
                    menu_sel    = MENU_SEL_WIDTH'(2);
                    debug_state = DBG_MENU_WAIT_TONE;
                end
                MENU_WAIT_SONG: begin
                    store_song  = 1'b1;
                    show_menu   = 1'b1;
                    menu_sel    = MENU_SEL_WIDTH'(3);
                    debug_state = DBG_MENU_WAIT_SONG;
                end
                default: debug_state = DBG_MENU_LAUNCH;
            endcase
        end else begin
            start_menu  = (play_state == PLAY_ERROR_MENU_START);
            show_menu   = (play_state == PLAY_ERROR_MENU);
            // Error menu page
            menu_sel    = (play_state == PLAY_ERROR_MENU) ? MENU_SEL_WIDTH'(4) : '0;
            debug_state = play_code(play_state);
        end
    end

endmodule

//--- play_sequencer.sv
`timescale 1ns/100ps

module play_sequencer (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic                                       game_start,
    input  logic [control_pkg::MODE_WIDTH-1:0]         modes,
    input  logic [control_pkg::ERROR_CHOICE_WIDTH-1:0] error_choice,
    input  logic                                       enter,
    input  logic                                       start,
    input  logic                                       delay_done,
    input  logic                                       rounds_done,
    input  logic                                       note_made,
    input  logic                                       note_correct,
    input  logic                                       time_correct,
    input  logic                                       beat_low,
    input  logic                                       address_at_round,
    input  logic                                       timeout,
    input  logic                                       song_end,
    output control_pkg::play_state_t                   play_state
);
    import control_pkg::*;

    play_state_t next_state;
    logic        game_mode;

    assign game_mode = modes[MODE_GAME];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            play_state <= PLAY_IDLE;
        end else begin
            play_state <= next_state;
        end
    end

    always_comb begin
        next_state = play_state;
        case (play_state)
            PLAY_IDLE: begin
                if (game_start) begin
                    next_state = PLAY_INIT;
                end
            end
            PLAY_INIT: begin
                if (game_mode) begin
                    next_state = PLAY_ROUND_START;
                end else if (modes[MODE_FREE]) begin
                    next_state = PLAY_FREE_WAIT;
                end else begin
                    next_state = PLAY_IDLE;
                end
            end
            PLAY_ROUND_START: begin
                if (delay_done) begin
                    next_state = PLAY_SHOW;
                end
            end

            // ------------------------------------------------
            // Sequence preview
            // ------------------------------------------------
            PLAY_SHOW:      next_state = PLAY_SHOW_WAIT;
            PLAY_SHOW_WAIT: begin
                if (beat_low) begin
                    next_state = address_at_round ? PLAY_NOTE_START : PLAY_SHOW_NEXT;
                end
            end
            PLAY_SHOW_NEXT: next_state = PLAY_SHOW;

            // ------------------------------------------------
            // Player input
            // ------------------------------------------------
            PLAY_NOTE_START: next_state = PLAY_NOTE_WAIT;
            PLAY_NOTE_WAIT: begin
                if (timeout) begin
                    next_state = PLAY_WRONG_TIME;
                end else if (note_made) begin
                    next_state = PLAY_NOTE_SOUND;
                end
            end
            PLAY_NOTE_SOUND: begin
                // Key released
                if (!note_made) begin
                    next_state = game_mode ? PLAY_COMPARE : PLAY_FREE_WAIT;
                end
            end
            PLAY_COMPARE: begin
                if (!note_correct) begin
                    next_state = PLAY_WRONG_NOTE;
                end else if (!time_correct) begin
                    next_state = PLAY_WRONG_TIME;
                end else if (address_at_round && rounds_done) begin
                    next_state = PLAY_WON;
                end else if (address_at_round) begin
                    next_state = PLAY_ADVANCE;
                end else begin
                    next_state = PLAY_NEXT_NOTE;
                end
            end
            PLAY_NEXT_NOTE:  next_state = PLAY_NOTE_WAIT;
            PLAY_ADVANCE:    next_state = PLAY_RECORD;
            PLAY_RECORD:     next_state = PLAY_CHECK_END;
            PLAY_CHECK_END:  next_state = song_end ? PLAY_WON : PLAY_NEXT_ROUND;
            PLAY_NEXT_ROUND: next_state = PLAY_ROUND_START;
            PLAY_WON: begin
                if (start) begin
                    next_state = PLAY_INIT;
                end
            end

            // ------------------------------------------------
            // Errors
            // ------------------------------------------------
            PLAY_WRONG_NOTE,
            PLAY_WRONG_TIME:       next_state = PLAY_ERROR_MENU_START;
            PLAY_ERROR_MENU_START: next_state = PLAY_ERROR_MENU;
            PLAY_ERROR_MENU: begin
                if (enter && error_choice[CHOICE_RETRY_ROUND]) begin
                    next_state = PLAY_ROUND_START;
                end else if (enter && error_choice[CHOICE_RETRY_NOTE]) begin
                    next_state = PLAY_NOTE_START;
                end
            end

            PLAY_FREE_WAIT: begin
                if (note_made) begin
                    next_state = PLAY_NOTE_SOUND;
                end
            end
            default: next_state = PLAY_IDLE;
        endcase
    end

endmodule

//--- menu_sequencer.sv
`timescale 1ns/100ps

module menu_sequencer (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               start,
    input  logic                               enter,
    input  logic [control_pkg::MODE_WIDTH-1:0] modes,
    output control_pkg::menu_state_t           menu_state,
    output logic                               game_start
);
    import control_pkg::*;

    menu_state_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            menu_state <= MENU_IDLE;
        end else begin
            menu_state <= next_state;
        end
    end

    // One page per enter and no song page in free play
    always_comb begin
        next_state = menu_state;
        case (menu_state)
            MENU_IDLE: begin
                if (start) begin
                    next_state = MENU_START;
                end
            end
            MENU_START:     next_state = MENU_WAIT_MODE;
            MENU_WAIT_MODE: begin
                if (enter) begin
                    next_state = MENU_WAIT_BPM;
                end
            end
            MENU_WAIT_BPM: begin
                if (enter) begin
                    next_state = MENU_WAIT_TONE;
                end
            end
            MENU_WAIT_TONE: begin
                if (enter) begin
                    next_state = modes[MODE_FREE] ? MENU_LAUNCH : MENU_WAIT_SONG;
                end
            end
            MENU_WAIT_SONG: begin
                if (enter) begin
                    next_state = MENU_LAUNCH;
                end
            end
            MENU_LAUNCH:    next_state = MENU_PLAYING;
            // Parked until reset
            default:        next_state = MENU_PLAYING;
        endcase
    end

    assign game_start = (menu_state == MENU_LAUNCH);

endmodule

//--- control_pkg.sv
package control_pkg;

    // --------------------------------------------------
    // Selection widths and bit positions
    // --------------------------------------------------
    localparam int MODE_WIDTH         = 2;
    localparam int MODE_GAME          = 0;
    localparam int MODE_FREE          = 1;

    localparam int ERROR_CHOICE_WIDTH = 2;
    localparam int CHOICE_RETRY_ROUND = 0;
    localparam int CHOICE_RETRY_NOTE  = 1;

    localparam int MENU_SEL_WIDTH     = 3;
    localparam int DEBUG_WIDTH        = 6;

    // --------------------------------------------------
    // State encodings
    // --------------------------------------------------
    typedef enum logic [2:0] {
        MENU_IDLE, MENU_START, MENU_WAIT_MODE, MENU_WAIT_BPM,
        MENU_WAIT_TONE, MENU_WAIT_SONG, MENU_LAUNCH, MENU_PLAYING
    } menu_state_t;

    typedef enum logic [4:0] {
        PLAY_IDLE, PLAY_INIT, PLAY_ROUND_START,
        PLAY_SHOW, PLAY_SHOW_WAIT, PLAY_SHOW_NEXT,
        PLAY_NOTE_START, PLAY_NOTE_WAIT, PLAY_NOTE_SOUND, PLAY_COMPARE,
        PLAY_NEXT_NOTE, PLAY_ADVANCE, PLAY_RECORD, PLAY_CHECK_END, PLAY_NEXT_ROUND,
        PLAY_WON, PLAY_WRONG_NOTE, PLAY_WRONG_TIME,
        PLAY_ERROR_MENU_START, PLAY_ERROR_MENU,
        PLAY_FREE_WAIT
    } play_state_t;

    // --------------------------------------------------
    // Debug codes shown on the display
    // --------------------------------------------------
    localparam logic [DEBUG_WIDTH-1:0] DBG_MENU_IDLE         = 6'h00;
    localparam logic [DEBUG_WIDTH-1:0] DBG_MENU_START        = 6'h1C;
    localparam logic [DEBUG_WIDTH-1:0] DBG_MENU_WAIT_MODE    = 6'h1D;
    localparam logic [DEBUG_WIDTH-1:0] DBG_MENU_WAIT_BPM     = 6'h1E;
    localparam logic [DEBUG_WIDTH-1:0] DBG_MENU_WAIT_TONE    = 6'h1F;
    localparam logic [DEBUG_WIDTH-1:0] DBG_MENU_WAIT_SONG    = 6'h20;
    // Launch state has a code of its own
    localparam logic [DEBUG_WIDTH-1:0] DBG_MENU_LAUNCH       = 6'h2F;

    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_IDLE         = 6'h00;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_INIT         = 6'h01;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_ROUND_START  = 6'h02;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_SHOW         = 6'h03;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_SHOW_WAIT    = 6'h04;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_SHOW_NEXT    = 6'h05;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_NOTE_START   = 6'h06;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_NOTE_WAIT    = 6'h07;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_COMPARE      = 6'h09;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_WON          = 6'h0A;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_NEXT_NOTE    = 6'h0B;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_ADVANCE      = 6'h13;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_WRONG_NOTE   = 6'h14;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_WRONG_TIME   = 6'h15;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_NOTE_SOUND   = 6'h17;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_NEXT_ROUND   = 6'h19;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_CHECK_END    = 6'h1A;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_RECORD       = 6'h1B;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_ERROR_START  = 6'h21;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_ERROR_MENU   = 6'h22;
    localparam logic [DEBUG_WIDTH-1:0] DBG_PLAY_FREE_WAIT    = 6'h23;

endpackage
